// ==== common/cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

`define CACHE_WAYS      2
`define CACHE_BANKS     4
`define CACHE_INDEX_W   8
`define CACHE_TAG_W     20
`define CACHE_OFFSET_W  4
`define CACHE_WORD_W    32
`define CACHE_LINE_W    128     // all banks of one line

// derived widths
`define CACHE_WAY_W     $clog2(`CACHE_WAYS)
`define CACHE_BANK_W    $clog2(`CACHE_BANKS)
`define CACHE_STRB_W    (`CACHE_WORD_W / 8)

`endif

// ==== common/cache_pkg.sv ====
`include "cache_config.svh"

package cache_pkg;

    typedef struct packed {
        logic                       op;     // 1 = store
        logic [`CACHE_INDEX_W-1:0]  index;
        logic [`CACHE_TAG_W-1:0]    tag;
        logic [`CACHE_OFFSET_W-1:0] offset;
        logic [`CACHE_STRB_W-1:0]   wstrb;
        logic [`CACHE_WORD_W-1:0]   wdata;
    } cache_req_t;

    typedef struct packed {
        logic [`CACHE_TAG_W-1:0] tag;
        logic                    valid;
    } tagv_t;

    // bus address, as a raw word or split into its line fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [`CACHE_TAG_W-1:0]    tag;
            logic [`CACHE_INDEX_W-1:0]  index;
            logic [`CACHE_OFFSET_W-1:0] offset;
        } f;
    } line_addr_u;

endpackage

// ==== rtl/cache_ram.sv ====
`timescale 1ns/10ps
`include "cache_config.svh"

module cache_ram #(
    parameter int  DEPTH_W = `CACHE_INDEX_W,
    parameter int  DATA_W  = `CACHE_WORD_W,
    localparam int WE_W    = (DATA_W % 8 == 0) ? DATA_W / 8 : 1,  // one enable for odd widths
    localparam int LANE_W  = DATA_W / WE_W
) (
    input  logic               clk,
    input  logic               en,
    input  logic [WE_W-1:0]    we,
    input  logic [DEPTH_W-1:0] addr,
    input  logic [DATA_W-1:0]  wdata,
    output logic [DATA_W-1:0]  rdata
);

    logic [DATA_W-1:0] mem [0:(1 << DEPTH_W)-1];

    // block ram comes up cleared, so no line starts valid
    initial begin
        for (int i = 0; i < (1 << DEPTH_W); i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < WE_W; i++) begin
                if (we[i]) begin
                    mem[addr][i*LANE_W +: LANE_W] <= wdata[i*LANE_W +: LANE_W];
                end
            end
            rdata <= mem[addr];     // read-first
        end
    end

endmodule

// ==== cache/cache_storage.sv ====
`timescale 1ns/10ps
`include "cache_config.svh"

module cache_storage import cache_pkg::*; (
    input  logic                        clk,
    input  logic                        lookup,
    input  logic [`CACHE_INDEX_W-1:0]   lookup_index,
    input  logic [`CACHE_BANK_W-1:0]    lookup_bank,
    input  logic                        fill_we,
    input  logic [`CACHE_WAY_W-1:0]     fill_way,
    input  logic [`CACHE_INDEX_W-1:0]   fill_index,
    input  logic [`CACHE_BANK_W-1:0]    fill_bank,
    input  tagv_t                       fill_tagv,
    input  logic [`CACHE_WORD_W-1:0]    fill_word,
    input  logic                        hw_we,
    input  logic [`CACHE_WAY_W-1:0]     hw_way,
    input  logic [`CACHE_INDEX_W-1:0]   hw_index,
    input  logic [`CACHE_BANK_W-1:0]    hw_bank,
    input  logic [`CACHE_STRB_W-1:0]    hw_strb,
    input  logic [`CACHE_WORD_W-1:0]    hw_word,
    output tagv_t [`CACHE_WAYS-1:0]     way_tagv,
    output logic [`CACHE_WAYS-1:0][`CACHE_LINE_W-1:0] way_line
);

    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
        localparam logic [`CACHE_WAY_W-1:0] WAY = w;
        logic tag_fill;

        assign tag_fill = fill_we && fill_way == WAY;

        // tag written once, on the beat of the requested bank
        cache_ram #(.DEPTH_W(`CACHE_INDEX_W), .DATA_W($bits(tagv_t))) i_tagv (
            .clk   (clk),
            .en    (lookup || tag_fill),
            .we    (tag_fill && fill_bank == lookup_bank),
            .addr  (tag_fill ? fill_index : lookup_index),
            .wdata (fill_tagv),
            .rdata (way_tagv[w])
        );

        for (genvar b = 0; b < `CACHE_BANKS; b++) begin : g_bank
            localparam logic [`CACHE_BANK_W-1:0] BANK = b;
            logic hw_sel;
            logic fill_sel;
            logic rd_sel;

            assign hw_sel   = hw_we && hw_way == WAY && hw_bank == BANK;
            assign fill_sel = fill_we && fill_way == WAY && fill_bank == BANK;
            // whole line when the port is free, else only the requested bank
            assign rd_sel   = lookup && (lookup_bank == BANK || !hw_we);

            cache_ram #(.DEPTH_W(`CACHE_INDEX_W), .DATA_W(`CACHE_WORD_W)) i_bank (
                .clk   (clk),
                .en    (hw_sel || fill_sel || rd_sel),
                .we    (hw_sel ? hw_strb : {`CACHE_STRB_W{fill_sel}}),
                .addr  (hw_sel ? hw_index : (fill_sel ? fill_index : lookup_index)),
                .wdata (hw_sel ? hw_word : fill_word),
                .rdata (way_line[w][b*`CACHE_WORD_W +: `CACHE_WORD_W])
            );
        end
    end

    // refill only runs with the store buffer empty
    a_no_fill_hw: assert property (@(posedge clk) !(fill_we && hw_we));

endmodule

// ==== cache/store_buffer.sv ====
`timescale 1ns/10ps
`include "cache_config.svh"

module store_buffer (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        load,
    input  logic [`CACHE_WAY_W-1:0]     way,
    input  logic [`CACHE_BANK_W-1:0]    bank,
    input  logic [`CACHE_INDEX_W-1:0]   index,
    input  logic [`CACHE_STRB_W-1:0]    wstrb,
    input  logic [`CACHE_WORD_W-1:0]    wdata,
    output logic                        hw_we,
    output logic [`CACHE_WAY_W-1:0]     hw_way,
    output logic [`CACHE_INDEX_W-1:0]   hw_index,
    output logic [`CACHE_BANK_W-1:0]    hw_bank,
    output logic [`CACHE_STRB_W-1:0]    hw_strb,
    output logic [`CACHE_WORD_W-1:0]    hw_word,
    output logic                        dirty_set,
    output logic [`CACHE_WAY_W-1:0]     dirty_way,
    output logic [`CACHE_INDEX_W-1:0]   dirty_index
);

    logic pend;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pend <= 1'b0;
        end else begin
            pend <= load;   // one cycle only
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            hw_way   <= way;
            hw_bank  <= bank;
            hw_index <= index;
            hw_strb  <= wstrb;
            hw_word  <= wdata;
        end
    end

    assign hw_we       = pend;
    assign dirty_set   = pend;
    assign dirty_way   = hw_way;
    assign dirty_index = hw_index;

endmodule

// ==== cache/cache_ctrl.sv ====
`timescale 1ns/10ps
`include "cache_config.svh"

module cache_ctrl import cache_pkg::*; (
    input  logic                        clk,
    input  logic                        resetn,
    input  cache_req_t                  req,
    input  logic                        valid,
    output logic                        addr_ok,
    output logic                        data_ok,
    output logic [`CACHE_WORD_W-1:0]    rdata,
    input  tagv_t [`CACHE_WAYS-1:0]     way_tagv,
    input  logic [`CACHE_WAYS-1:0][`CACHE_LINE_W-1:0] way_line,
    output logic                        lookup,
    output logic [`CACHE_INDEX_W-1:0]   lookup_index,
    output logic [`CACHE_BANK_W-1:0]    lookup_bank,
    output logic                        fill_we,
    output logic [`CACHE_WAY_W-1:0]     fill_way,
    output logic [`CACHE_INDEX_W-1:0]   fill_index,
    output logic [`CACHE_BANK_W-1:0]    fill_bank,
    output tagv_t                       fill_tagv,
    output logic [`CACHE_WORD_W-1:0]    fill_word,
    output logic                        sb_load,
    output logic [`CACHE_WAY_W-1:0]     sb_way,
    output logic [`CACHE_BANK_W-1:0]    sb_bank,
    output logic [`CACHE_INDEX_W-1:0]   sb_index,
    output logic [`CACHE_STRB_W-1:0]    sb_wstrb,
    output logic [`CACHE_WORD_W-1:0]    sb_wdata,
    input  logic                        hw_we,
    input  logic [`CACHE_BANK_W-1:0]    hw_bank,
    input  logic                        dirty_set,
    input  logic [`CACHE_WAY_W-1:0]     dirty_way,
    input  logic [`CACHE_INDEX_W-1:0]   dirty_index,
    output logic                        rd_req,
    output logic [31:0]                 rd_addr,
    input  logic                        rd_rdy,
    input  logic                        ret_valid,
    input  logic                        ret_last,
    input  logic [`CACHE_WORD_W-1:0]    ret_data,
    output logic                        wr_req,
    output logic [31:0]                 wr_addr,
    output logic [`CACHE_LINE_W-1:0]    wr_data,
    input  logic                        wr_rdy
);

    localparam logic [2:0] S_IDLE    = 3'd0;
    localparam logic [2:0] S_LOOKUP  = 3'd1;
    localparam logic [2:0] S_MISS    = 3'd2;
    localparam logic [2:0] S_REPLACE = 3'd3;
    localparam logic [2:0] S_REFILL  = 3'd4;

    logic [2:0] state;
    logic [2:0] state_nxt;
    cache_req_t r;
    logic [`CACHE_BANK_W-1:0] r_bank;
    logic [`CACHE_BANK_W-1:0] cnt;
    logic [`CACHE_WAYS-1:0] way_hit;
    logic hit;
    logic [`CACHE_WAY_W-1:0] hit_way;
    logic [`CACHE_WAY_W-1:0] victim;
    logic victim_dirty;
    logic stall;
    logic accept;
    logic [`CACHE_WAYS-1:0][(1 << `CACHE_INDEX_W)-1:0] dirty;
    logic [`CACHE_WORD_W-1:0] merged;
    line_addr_u rd_a;
    line_addr_u wr_a;

    assign r_bank  = r.offset[`CACHE_OFFSET_W-1:2];
    // load would read the bank the store buffer is writing
    assign stall   = valid && !req.op && hw_we && req.offset[`CACHE_OFFSET_W-1:2] == hw_bank;
    assign addr_ok = state == S_IDLE && !stall;
    assign accept  = valid && addr_ok;

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            way_hit[w] = way_tagv[w].valid && way_tagv[w].tag == r.tag;
        end
    end
    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    assign victim_dirty = way_tagv[victim].valid && dirty[victim][r.index];

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:    if (accept) state_nxt = S_LOOKUP;
            S_LOOKUP:  state_nxt = hit ? S_IDLE : S_MISS;
            S_MISS:    if (wr_rdy || !victim_dirty) state_nxt = S_REPLACE;
            S_REPLACE: if (rd_rdy) state_nxt = S_REFILL;
            S_REFILL:  if (ret_valid && ret_last) state_nxt = S_IDLE;
            default:   state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            r <= req;
        end
    end

    // refill beat count, pointer and dirty table
    always_ff @(posedge clk) begin
        if (!resetn) begin
            cnt    <= '0;
            victim <= '0;
            dirty  <= '0;
        end else begin
            if (state == S_REFILL && ret_valid) begin
                cnt <= ret_last ? '0 : cnt + 1'b1;
            end
            if (state == S_REFILL && ret_valid && ret_last) begin
                victim <= ~victim;
            end
            if (dirty_set) begin
                dirty[dirty_way][dirty_index] <= 1'b1;
            end else if (state == S_REFILL && ret_valid && ret_last) begin
                dirty[victim][r.index] <= r.op;     // clean after a load miss
            end
        end
    end

    // a miss reads the whole victim line again for the write-back
    assign lookup       = accept || (state == S_LOOKUP && !hit);
    assign lookup_index = (state == S_IDLE) ? req.index : r.index;
    assign lookup_bank  = (state == S_IDLE) ? req.offset[`CACHE_OFFSET_W-1:2] : r_bank;

    always_comb begin
        for (int i = 0; i < `CACHE_STRB_W; i++) begin
            merged[i*8 +: 8] = r.wstrb[i] ? r.wdata[i*8 +: 8] : ret_data[i*8 +: 8];
        end
    end

    assign fill_we    = state == S_REFILL && ret_valid;
    assign fill_way   = victim;
    assign fill_index = r.index;
    assign fill_bank  = cnt;
    assign fill_tagv  = '{tag: r.tag, valid: 1'b1};
    assign fill_word  = (r.op && cnt == r_bank) ? merged : ret_data;

    assign sb_load  = state == S_LOOKUP && hit && r.op;
    assign sb_way   = hit_way;
    assign sb_bank  = r_bank;
    assign sb_index = r.index;
    assign sb_wstrb = r.wstrb;
    assign sb_wdata = r.wdata;

    // stores finish at lookup whether they hit or miss
    assign data_ok = state == S_LOOKUP && (hit || r.op)
                  || state == S_REFILL && ret_valid && cnt == r_bank && !r.op;
    assign rdata   = (state == S_REFILL) ? ret_data
                   : way_line[hit_way][r_bank*`CACHE_WORD_W +: `CACHE_WORD_W];

    always_comb begin
        rd_a.f.tag    = r.tag;
        rd_a.f.index  = r.index;
        rd_a.f.offset = '0;
        wr_a.f.tag    = way_tagv[victim].tag;
        wr_a.f.index  = r.index;
        wr_a.f.offset = '0;
    end

    assign rd_req  = state == S_REPLACE;
    assign rd_addr = rd_a.raw;
    assign wr_req  = state == S_MISS && victim_dirty;
    assign wr_addr = wr_a.raw;
    assign wr_data = way_line[victim];

    // beats only arrive for a refill in flight
    a_ret_in_refill: assert property (@(posedge clk) disable iff (!resetn)
        ret_valid |-> state == S_REFILL);
    a_four_beats: assert property (@(posedge clk) disable iff (!resetn)
        state == S_REFILL && ret_valid && cnt == '1 |-> ret_last);

endmodule

// ==== cache/cache_top.sv ====
`timescale 1ns/10ps
`include "cache_config.svh"

module cache_top import cache_pkg::*; (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        valid,
    input  logic                        op,
    input  logic [`CACHE_INDEX_W-1:0]   index,
    input  logic [`CACHE_TAG_W-1:0]     tag,
    input  logic [`CACHE_OFFSET_W-1:0]  offset,
    input  logic [`CACHE_STRB_W-1:0]    wstrb,
    input  logic [`CACHE_WORD_W-1:0]    wdata,
    output logic                        addr_ok,
    output logic                        data_ok,
    output logic [`CACHE_WORD_W-1:0]    rdata,
    output logic                        rd_req,
    output logic [31:0]                 rd_addr,
    input  logic                        rd_rdy,
    input  logic                        ret_valid,
    input  logic                        ret_last,
    input  logic [`CACHE_WORD_W-1:0]    ret_data,
    output logic                        wr_req,
    output logic [31:0]                 wr_addr,
    output logic [`CACHE_LINE_W-1:0]    wr_data,
    input  logic                        wr_rdy
);

    cache_req_t req;
    tagv_t [`CACHE_WAYS-1:0] way_tagv;
    logic [`CACHE_WAYS-1:0][`CACHE_LINE_W-1:0] way_line;
    logic lookup;
    logic [`CACHE_INDEX_W-1:0] lookup_index;
    logic [`CACHE_BANK_W-1:0] lookup_bank;
    logic fill_we;
    logic [`CACHE_WAY_W-1:0] fill_way;
    logic [`CACHE_INDEX_W-1:0] fill_index;
    logic [`CACHE_BANK_W-1:0] fill_bank;
    tagv_t fill_tagv;
    logic [`CACHE_WORD_W-1:0] fill_word;
    logic sb_load;
    logic [`CACHE_WAY_W-1:0] sb_way;
    logic [`CACHE_BANK_W-1:0] sb_bank;
    logic [`CACHE_INDEX_W-1:0] sb_index;
    logic [`CACHE_STRB_W-1:0] sb_wstrb;
    logic [`CACHE_WORD_W-1:0] sb_wdata;
    logic hw_we;
    logic [`CACHE_WAY_W-1:0] hw_way;
    logic [`CACHE_INDEX_W-1:0] hw_index;
    logic [`CACHE_BANK_W-1:0] hw_bank;
    logic [`CACHE_STRB_W-1:0] hw_strb;
    logic [`CACHE_WORD_W-1:0] hw_word;
    logic dirty_set;
    logic [`CACHE_WAY_W-1:0] dirty_way;
    logic [`CACHE_INDEX_W-1:0] dirty_index;

    assign req = '{op: op, index: index, tag: tag, offset: offset,
                   wstrb: wstrb, wdata: wdata};

    cache_ctrl i_ctrl (
        .clk, .resetn, .req, .valid, .addr_ok, .data_ok, .rdata,
        .way_tagv, .way_line, .lookup, .lookup_index, .lookup_bank,
        .fill_we, .fill_way, .fill_index, .fill_bank, .fill_tagv, .fill_word,
        .sb_load, .sb_way, .sb_bank, .sb_index, .sb_wstrb, .sb_wdata,
        .hw_we, .hw_bank, .dirty_set, .dirty_way, .dirty_index,
        .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy
    );

    cache_storage i_storage (
        .clk, .lookup, .lookup_index, .lookup_bank,
        .fill_we, .fill_way, .fill_index, .fill_bank, .fill_tagv, .fill_word,
        .hw_we, .hw_way, .hw_index, .hw_bank, .hw_strb, .hw_word,
        .way_tagv, .way_line
    );

    store_buffer i_sb (
        .clk,
        .resetn,
        .load  (sb_load),
        .way   (sb_way),
        .bank  (sb_bank),
        .index (sb_index),
        .wstrb (sb_wstrb),
        .wdata (sb_wdata),
        .hw_we, .hw_way, .hw_index, .hw_bank, .hw_strb, .hw_word,
        .dirty_set, .dirty_way, .dirty_index
    );

endmodule

// ==== verification/mem_model.sv ====
`timescale 1ns/10ps
`include "cache_config.svh"

module mem_model (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        rd_req,
    input  logic [31:0]                 rd_addr,
    output logic                        rd_rdy,
    output logic                        ret_valid,
    output logic                        ret_last,
    output logic [`CACHE_WORD_W-1:0]    ret_data,
    input  logic                        wr_req,
    input  logic [31:0]                 wr_addr,
    input  logic [`CACHE_LINE_W-1:0]    wr_data,
    output logic                        wr_rdy
);

    logic [31:0] mem [logic [29:0]];    // written-back words only

    function automatic logic [31:0] read_word(input logic [31:0] a);
        if (mem.exists(a[31:2])) begin
            return mem[a[31:2]];
        end
        return {a[31:2], 2'b00} ^ 32'h5a5a0000;     // untouched memory
    endfunction

    initial begin
        logic [31:0] a;
        logic [`CACHE_LINE_W-1:0] line;
        int gap;
        rd_rdy    <= 1'b0;
        wr_rdy    <= 1'b0;
        ret_valid <= 1'b0;
        ret_last  <= 1'b0;
        ret_data  <= '0;
        forever begin
            @(negedge clk);
            if (resetn && wr_req) begin
                a    = wr_addr;
                line = wr_data;
                gap  = $urandom_range(3, 0);
                repeat (gap) @(posedge clk);
                @(posedge clk);
                wr_rdy <= 1'b1;
                @(posedge clk);
                wr_rdy <= 1'b0;
                for (int i = 0; i < `CACHE_BANKS; i++) begin
                    mem[{a[31:4], 2'(i)}] = line[i*`CACHE_WORD_W +: `CACHE_WORD_W];
                end
            end else if (resetn && rd_req) begin
                a   = rd_addr;
                gap = $urandom_range(3, 0);
                repeat (gap) @(posedge clk);
                @(posedge clk);
                rd_rdy <= 1'b1;
                @(posedge clk);
                rd_rdy <= 1'b0;
                // lowest word first
                for (int i = 0; i < `CACHE_BANKS; i++) begin
                    ret_valid <= 1'b1;
                    ret_last  <= i == `CACHE_BANKS - 1;
                    ret_data  <= read_word({a[31:4], 2'(i), 2'b00});
                    @(posedge clk);
                end
                ret_valid <= 1'b0;
                ret_last  <= 1'b0;
            end
        end
    end

endmodule

// ==== verification/cache_tb.sv ====
`timescale 1ns/10ps
`include "cache_config.svh"

module cache_tb import cache_pkg::*; ();

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 10;
    localparam int N_TESTS      = 6;
    localparam int TEST_CYCLES  = 200;

    logic clk;
    logic resetn;
    logic valid;
    logic op;
    logic [`CACHE_INDEX_W-1:0] index;
    logic [`CACHE_TAG_W-1:0] tag;
    logic [`CACHE_OFFSET_W-1:0] offset;
    logic [`CACHE_STRB_W-1:0] wstrb;
    logic [`CACHE_WORD_W-1:0] wdata;
    logic addr_ok;
    logic data_ok;
    logic [`CACHE_WORD_W-1:0] rdata;
    logic rd_req;
    logic [31:0] rd_addr;
    logic rd_rdy;
    logic ret_valid;
    logic ret_last;
    logic [`CACHE_WORD_W-1:0] ret_data;
    logic wr_req;
    logic [31:0] wr_addr;
    logic [`CACHE_LINE_W-1:0] wr_data;
    logic wr_rdy;

    logic [31:0] golden [logic [29:0]];     // word addressed
    logic cur_op = 1'b0;
    logic [31:0] cur_exp = '0;
    logic [31:0] cur_line = '0;
    logic expect_hit = 1'b0;
    logic wb_check = 1'b0;
    logic [31:0] wb_cand0 = '0;
    logic [31:0] wb_cand1 = '0;
    string test_name = "reset";
    int errors = 0;
    int err_base = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int rd_seen = 0;
    int wr_seen = 0;
    int stall_seen = 0;
    logic [1:0] st_hit_age = '0;    // store hit accepted one and two cycles back
    logic [`CACHE_BANK_W-1:0] st_bank = '0;
    logic conflict;

    cache_top i_dut (
        .clk, .resetn, .valid, .op, .index, .tag, .offset, .wstrb, .wdata,
        .addr_ok, .data_ok, .rdata,
        .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy
    );

    mem_model i_mem (
        .clk, .resetn, .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy
    );

    function automatic logic [31:0] golden_word(input logic [31:0] a);
        if (golden.exists(a[31:2])) begin
            return golden[a[31:2]];
        end
        return {a[31:2], 2'b00} ^ 32'h5a5a0000;
    endfunction

    function automatic logic [`CACHE_LINE_W-1:0] golden_line(input logic [31:0] a);
        logic [`CACHE_LINE_W-1:0] line;
        logic [31:0] w_addr;
        for (int i = 0; i < `CACHE_BANKS; i++) begin
            w_addr = {a[31:4], 4'h0} + i * 4;
            line[i*`CACHE_WORD_W +: `CACHE_WORD_W] = golden_word(w_addr);
        end
        return line;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] d,
                                                input logic [3:0] strb);
        logic [31:0] m;
        m = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                m[i*8 +: 8] = d[i*8 +: 8];
            end
        end
        return m;
    endfunction

    function automatic logic [3:0] rand_strb();
        logic [31:0] r;
        r = $urandom();
        return r[3:0];
    endfunction

    // a store hit writes its bank in the second cycle after acceptance
    assign conflict = st_hit_age[1] && valid && !op && offset[`CACHE_OFFSET_W-1:2] == st_bank;

    a_reset: assert property (@(posedge clk) resetn && !$past(resetn)
        |-> addr_ok && !data_ok && !rd_req && !wr_req)
        else begin
            errors++;
            $display("Error %0s: addr_ok,data_ok,rd_req,wr_req expected 1000, actual %b%b%b%b",
                     test_name, addr_ok, data_ok, rd_req, wr_req);
        end

    // hits and all stores answer in the cycle after acceptance
    a_latency: assert property (@(posedge clk) disable iff (!resetn)
        valid && addr_ok && (op || expect_hit) |=> data_ok)
        else begin
            errors++;
            $display("Error %0s: data_ok after acceptance expected 1, actual %b",
                     test_name, data_ok);
        end

    a_load_data: assert property (@(posedge clk) disable iff (!resetn)
        data_ok && !cur_op |-> rdata == cur_exp)
        else begin
            errors++;
            $display("Error %0s: rdata expected %h, actual %h", test_name, cur_exp, rdata);
        end

    a_stall: assert property (@(posedge clk) disable iff (!resetn)
        conflict |-> !addr_ok)
        else begin
            errors++;
            $display("Error %0s: addr_ok on bank conflict expected 0, actual %b",
                     test_name, addr_ok);
        end

    a_rd_addr: assert property (@(posedge clk) disable iff (!resetn)
        rd_req |-> rd_addr == cur_line)
        else begin
            errors++;
            $display("Error %0s: rd_addr expected %h, actual %h", test_name, cur_line, rd_addr);
        end

    a_wr_data: assert property (@(posedge clk) disable iff (!resetn)
        wr_req |-> wr_data == golden_line(wr_addr))
        else begin
            errors++;
            $display("Error %0s: wr_data expected %h, actual %h",
                     test_name, golden_line(wr_addr), wr_data);
        end

    a_wr_addr: assert property (@(posedge clk) disable iff (!resetn)
        wr_req && wb_check |-> wr_addr == wb_cand0 || wr_addr == wb_cand1)
        else begin
            errors++;
            $display("Error %0s: wr_addr expected %h or %h, actual %h",
                     test_name, wb_cand0, wb_cand1, wr_addr);
        end

    always @(posedge clk) begin
        st_hit_age <= {st_hit_age[0], valid && addr_ok && op && expect_hit};
        if (valid && addr_ok && op) begin
            st_bank <= offset[`CACHE_OFFSET_W-1:2];
        end
        if (rd_req && rd_rdy) begin
            rd_seen <= rd_seen + 1;
        end
        if (wr_req && wr_rdy) begin
            wr_seen <= wr_seen + 1;
        end
        if (conflict) begin
            stall_seen <= stall_seen + 1;
        end
    end

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(PERIOD * (RESET_CYCLES + N_TESTS * TEST_CYCLES));
        $display("watchdog: run did not finish within %0d cycles",
                 RESET_CYCLES + N_TESTS * TEST_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    // drives one request and waits for data_ok
    task automatic access(input logic st, input logic [31:0] a, input logic [3:0] strb,
                          input logic [31:0] d, input logic hit);
        line_addr_u la;
        la.raw = a;
        @(posedge clk);
        valid      <= 1'b1;
        op         <= st;
        tag        <= la.f.tag;
        index      <= la.f.index;
        offset     <= la.f.offset;
        wstrb      <= strb;
        wdata      <= d;
        expect_hit <= hit;
        @(negedge clk);
        while (!addr_ok) @(negedge clk);
        @(posedge clk);     // accepted here
        valid    <= 1'b0;
        la.f.offset = '0;
        cur_line <= la.raw;
        cur_op   <= st;
        cur_exp  <= golden_word(a);
        if (st) begin
            golden[a[31:2]] = merge_bytes(golden_word(a), d, strb);
        end
        @(negedge clk);
        while (!data_ok) @(negedge clk);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_base  = errors;
    endtask

    task automatic end_test();
        int n;
        n = errors - err_base;
        tests_run++;
        if (n != 0) begin
            tests_failed++;
        end
        $display("test %0s: %0s, %0d errors", test_name, n == 0 ? "passed" : "failed", n);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("%0s: %0s", test_name, msg);
    endtask

    initial begin
        int seen;
        void'($urandom(32'h2ad5));
        resetn <= 1'b0;
        valid  <= 1'b0;
        op     <= 1'b0;
        index  <= '0;
        tag    <= '0;
        offset <= '0;
        wstrb  <= '0;
        wdata  <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;

        begin_test("reset");
        repeat (2) @(negedge clk);
        end_test();

        begin_test("read miss");
        seen = rd_seen;
        access(1'b0, 32'h1234_5678, 4'h0, '0, 1'b0);
        if (rd_seen == seen) report_problem("read miss did not request a refill");
        end_test();

        begin_test("read hit");
        seen = rd_seen;
        access(1'b0, 32'h1234_5678, 4'h0, '0, 1'b1);
        access(1'b0, 32'h1234_567c, 4'h0, '0, 1'b1);
        access(1'b0, 32'h1234_5670, 4'h0, '0, 1'b1);
        if (rd_seen != seen) report_problem("a read hit started a refill");
        end_test();

        begin_test("store hit");
        seen = stall_seen;
        access(1'b1, 32'h1234_5678, rand_strb(), $urandom(), 1'b1);
        access(1'b0, 32'h1234_5678, 4'h0, '0, 1'b1);    // same bank so it stalls one cycle
        access(1'b1, 32'h1234_5670, rand_strb(), $urandom(), 1'b1);
        access(1'b0, 32'h1234_5670, 4'h0, '0, 1'b1);
        if (stall_seen == seen) report_problem("no load was stalled by the store buffer");
        end_test();

        begin_test("store miss");
        seen = rd_seen;
        access(1'b1, 32'h0abc_d124, rand_strb(), $urandom(), 1'b0);
        access(1'b0, 32'h0abc_d124, 4'h0, '0, 1'b1);
        access(1'b0, 32'h0abc_d12c, 4'h0, '0, 1'b1);
        if (rd_seen == seen) report_problem("store miss did not refill the line");
        end_test();

        begin_test("write-back");
        seen     = wr_seen;
        wb_cand0 = 32'h1000_0550;
        wb_cand1 = 32'h2000_0550;
        wb_check = 1'b1;
        access(1'b1, 32'h1000_0554, rand_strb(), $urandom(), 1'b0);
        access(1'b1, 32'h2000_0558, rand_strb(), $urandom(), 1'b0);
        access(1'b1, 32'h3000_055c, rand_strb(), $urandom(), 1'b0);
        access(1'b0, 32'h3000_055c, 4'h0, '0, 1'b1);
        access(1'b0, 32'h1000_0554, 4'h0, '0, 1'b0);    // evicts the other dirty line
        if (wr_seen - seen < 2) report_problem("dirty victims were not written back");
        end_test();

        repeat (2) @(negedge clk);
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+common
common/cache_pkg.sv
rtl/cache_ram.sv
cache/cache_storage.sv
cache/store_buffer.sv
cache/cache_ctrl.sv
cache/cache_top.sv
verification/mem_model.sv
verification/cache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := cache_tb
FILELIST  := build.f
OBJDIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$($(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF '>>> PASS'

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
